/* hw/ialu_macros.svh */
`ifndef IALU_MACROS_SVH
`define IALU_MACROS_SVH

// Data word width
`define IALU_XLEN 32

// Shift amount taken from the low bits of op2
`define IALU_SHAMT_W 5

// Divider counter start value, one-hot
// Bit 0 is reached on the last iteration
`define IALU_DIV_CNT_INIT (`IALU_XLEN'(1) << (`IALU_XLEN - 2))

`endif

/* hw/ialu_cmd_pkg.sv */
`default_nettype none

package ialu_cmd_pkg;

    // Command encoding at the ALU ports
    typedef enum logic [3:0] {
        CMD_ADD  = 4'd0,
        CMD_SUB  = 4'd1,
        CMD_SLT  = 4'd2,    // Signed less-than
        CMD_SLTU = 4'd3,    // Unsigned less-than
        CMD_AND  = 4'd4,
        CMD_OR   = 4'd5,
        CMD_XOR  = 4'd6,
        CMD_SLL  = 4'd7,
        CMD_SRL  = 4'd8,
        CMD_SRA  = 4'd9,
        // Iterative divider commands
        CMD_DIV  = 4'd10,
        CMD_DIVU = 4'd11,
        CMD_REM  = 4'd12,
        CMD_REMU = 4'd13
    } ialu_cmd_e;

endpackage

`default_nettype wire

/* hw/ialu_div_pkg.sv */
`default_nettype none

package ialu_div_pkg;

    // Divider FSM states
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,    // First step or immediate result
        DIV_ITER = 2'd1,    // Remaining quotient bits
        DIV_CORR = 2'd2     // Sign fix-up of quotient or remainder
    } div_fsm_e;

endpackage

`default_nettype wire

/* hw/div_step_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Divider control <-> divider datapath
interface div_step_if ();

    ialu_div_pkg::div_fsm_e state;      // Current FSM state
    logic                   iter_last;  // Counter has reached bit 0
    logic                   upd;        // Update divider registers
    logic                   corr_req;   // Extra correction cycle needed

    modport ctrl_mp (
        output state,
        output iter_last,
        output upd,
        input  corr_req
    );

    modport dp_mp (
        input  state,
        input  iter_last,
        input  upd,
        output corr_req
    );

endinterface

`default_nettype wire

/* hw/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ialu_macros.svh"

module alu_core (
    input  ialu_cmd_pkg::ialu_cmd_e cmd_i,
    input  logic [`IALU_XLEN-1:0]   op1_i,
    input  logic [`IALU_XLEN-1:0]   op2_i,
    input  logic [`IALU_XLEN-1:0]   div_res_i,  // From divider datapath
    output logic [`IALU_XLEN-1:0]   res_o
);

    logic [`IALU_XLEN:0]      sum;      // MSB is carry/borrow
    logic                     sum_s;    // Sign
    logic                     sum_o;    // Overflow of op1 - op2
    logic                     sum_c;    // Borrow
    logic [`IALU_SHAMT_W-1:0] shamt;
    logic [`IALU_XLEN-1:0]    sll_res;
    logic [`IALU_XLEN-1:0]    srl_res;
    logic [`IALU_XLEN-1:0]    sra_res;

    // --------------------------------------------------
    // Adder and flags
    // --------------------------------------------------
    always_comb begin
        if (cmd_i == ialu_cmd_pkg::CMD_ADD) begin
            sum = {1'b0, op1_i} + {1'b0, op2_i};
        end else begin
            sum = {1'b0, op1_i} - {1'b0, op2_i};    // SUB, SLT, SLTU
        end
    end

    assign sum_s = sum[`IALU_XLEN-1];
    assign sum_c = sum[`IALU_XLEN];
    // Operands differ in sign and result sign flipped away from op1
    assign sum_o = (op1_i[`IALU_XLEN-1] ^ op2_i[`IALU_XLEN-1])
                 & (op1_i[`IALU_XLEN-1] ^ sum_s);

    // --------------------------------------------------
    // Shifter
    // --------------------------------------------------
    assign shamt   = op2_i[`IALU_SHAMT_W-1:0];
    assign sll_res = op1_i << shamt;
    assign srl_res = op1_i >> shamt;
    assign sra_res = $signed(op1_i) >>> shamt;  // Sign fill

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        res_o = '0;
        case (cmd_i)
            ialu_cmd_pkg::CMD_ADD,
            ialu_cmd_pkg::CMD_SUB  : res_o = sum[`IALU_XLEN-1:0];
            ialu_cmd_pkg::CMD_SLT  : res_o = `IALU_XLEN'(sum_s ^ sum_o);
            ialu_cmd_pkg::CMD_SLTU : res_o = `IALU_XLEN'(sum_c);
            ialu_cmd_pkg::CMD_AND  : res_o = op1_i & op2_i;
            ialu_cmd_pkg::CMD_OR   : res_o = op1_i | op2_i;
            ialu_cmd_pkg::CMD_XOR  : res_o = op1_i ^ op2_i;
            ialu_cmd_pkg::CMD_SLL  : res_o = sll_res;
            ialu_cmd_pkg::CMD_SRL  : res_o = srl_res;
            ialu_cmd_pkg::CMD_SRA  : res_o = sra_res;
            // Divider owns these
            ialu_cmd_pkg::CMD_DIV,
            ialu_cmd_pkg::CMD_DIVU,
            ialu_cmd_pkg::CMD_REM,
            ialu_cmd_pkg::CMD_REMU : res_o = div_res_i;
            default                : res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ialu_macros.svh"

module div_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_vld_i,  // Held until res_rdy_o
    input  ialu_cmd_pkg::ialu_cmd_e cmd_i,
    input  logic [`IALU_XLEN-1:0]   op1_i,
    input  logic [`IALU_XLEN-1:0]   op2_i,
    output logic                    res_rdy_o,
    div_step_if.ctrl_mp             ctrl
);

    logic                   cmd_div;    // Any of DIV/DIVU/REM/REMU
    logic                   ops_nz;     // Both operands nonzero
    logic                   iter_req;   // Start iterating
    logic                   iter_last;
    logic                   upd;
    logic                   fsm_idle;
    ialu_div_pkg::div_fsm_e fsm_ff;
    ialu_div_pkg::div_fsm_e fsm_next;
    logic [`IALU_XLEN-1:0]  iter_cnt;   // One-hot, walks toward bit 0

    assign cmd_div = (cmd_i == ialu_cmd_pkg::CMD_DIV)  | (cmd_i == ialu_cmd_pkg::CMD_DIVU)
                   | (cmd_i == ialu_cmd_pkg::CMD_REM)  | (cmd_i == ialu_cmd_pkg::CMD_REMU);
    assign ops_nz   = (|op1_i) & (|op2_i);
    assign fsm_idle = (fsm_ff == ialu_div_pkg::DIV_IDLE);
    assign iter_req = cmd_div & ops_nz & fsm_idle;

    assign iter_last = iter_cnt[0];
    assign upd       = cmd_vld_i & ~res_rdy_o;  // Busy and not finishing

    // Iteration counter
    always_ff @(posedge clk) begin
        if (upd) begin
            iter_cnt <= fsm_idle ? `IALU_DIV_CNT_INIT : (iter_cnt >> 1);
        end
    end

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= ialu_div_pkg::DIV_IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    always_comb begin
        fsm_next = ialu_div_pkg::DIV_IDLE;  // Valid low goes back to IDLE
        if (cmd_vld_i) begin
            case (fsm_ff)
                ialu_div_pkg::DIV_IDLE : begin
                    fsm_next = iter_req ? ialu_div_pkg::DIV_ITER : ialu_div_pkg::DIV_IDLE;
                end
                ialu_div_pkg::DIV_ITER : begin
                    fsm_next = !iter_last    ? ialu_div_pkg::DIV_ITER
                             : ctrl.corr_req ? ialu_div_pkg::DIV_CORR
                             :                 ialu_div_pkg::DIV_IDLE;
                end
                default : fsm_next = ialu_div_pkg::DIV_IDLE;    // CORR lasts one cycle
            endcase
        end
    end

    // Result ready
    always_comb begin
        res_rdy_o = 1'b1;   // Single-cycle commands
        if (cmd_div) begin
            case (fsm_ff)
                ialu_div_pkg::DIV_IDLE : res_rdy_o = ~iter_req;    // Zero operand
                ialu_div_pkg::DIV_ITER : res_rdy_o = iter_last & ~ctrl.corr_req;
                default                : res_rdy_o = 1'b1;
            endcase
        end
    end

    assign ctrl.state     = fsm_ff;
    assign ctrl.iter_last = iter_last;
    assign ctrl.upd       = upd;

endmodule

`default_nettype wire

/* hw/div_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ialu_macros.svh"

module div_datapath (
    input  logic                    clk,
    input  ialu_cmd_pkg::ialu_cmd_e cmd_i,
    input  logic [`IALU_XLEN-1:0]   op1_i,      // Dividend
    input  logic [`IALU_XLEN-1:0]   op2_i,      // Divisor
    output logic [`IALU_XLEN-1:0]   div_res_o,
    div_step_if.dp_mp               dp
);

    logic                   cmd_rem;    // REM or REMU
    logic                   cmd_sdiv;   // Signed quotient
    logic                   ops_sgn;    // Signed operands
    logic                   op1_neg;
    logic                   op2_neg;
    logic                   ops_diff;   // Operand signs differ
    logic                   st_idle;
    logic                   st_corr;

    // Divider adder
    logic                   sum_sub;
    logic [`IALU_XLEN:0]    sum_op1;
    logic [`IALU_XLEN:0]    sum_op2;
    logic [`IALU_XLEN:0]    sum;

    // Step results
    logic                   rem_c;
    logic [`IALU_XLEN-1:0]  rem;
    logic                   quo_bit;
    logic [`IALU_XLEN-1:0]  quo;
    logic [`IALU_XLEN-1:0]  dvd_lo_next;

    // Registers, loaded in IDLE before first use
    logic                   rem_c_ff;
    logic [`IALU_XLEN-1:0]  rem_ff;
    logic [`IALU_XLEN-1:0]  quo_ff;
    logic [`IALU_XLEN-1:0]  dvd_lo_ff;

    assign cmd_rem  = (cmd_i == ialu_cmd_pkg::CMD_REM) | (cmd_i == ialu_cmd_pkg::CMD_REMU);
    assign cmd_sdiv = (cmd_i == ialu_cmd_pkg::CMD_DIV);
    assign ops_sgn  = ~((cmd_i == ialu_cmd_pkg::CMD_DIVU) | (cmd_i == ialu_cmd_pkg::CMD_REMU));
    assign op1_neg  = ops_sgn & op1_i[`IALU_XLEN-1];
    assign op2_neg  = ops_sgn & op2_i[`IALU_XLEN-1];
    assign ops_diff = op1_i[`IALU_XLEN-1] ^ op2_i[`IALU_XLEN-1];
    assign st_idle  = (dp.state == ialu_div_pkg::DIV_IDLE);
    assign st_corr  = (dp.state == ialu_div_pkg::DIV_CORR);

    // --------------------------------------------------
    // Non-restoring step
    // --------------------------------------------------
    always_comb begin
        logic sgn;  // Direction from previous quotient bit
        logic inv;  // Mixed-sign signed operands flip direction
        sgn = st_corr ? (op1_neg ^ rem_c_ff)
            : st_idle ? 1'b0
            :           ~quo_ff[0];
        inv = ops_sgn & ops_diff;
        sum_sub = ~inv ^ sgn;
        sum_op1 = st_corr ? {1'b0, rem_ff}
                : st_idle ? {{`IALU_XLEN{op1_neg}}, op1_i[`IALU_XLEN-1]}   // Dividend MSB in
                :           {rem_ff, dvd_lo_ff[`IALU_XLEN-1]};
        sum_op2 = {op2_neg, op2_i};
        sum     = sum_sub ? (sum_op1 - sum_op2) : (sum_op1 + sum_op2);
    end

    assign rem_c       = sum[`IALU_XLEN];
    assign rem         = sum[`IALU_XLEN-1:0];
    assign dvd_lo_next = st_idle ? (op1_i << 1) : (dvd_lo_ff << 1);
    // Negative dividend needs the exact-zero case too
    assign quo_bit = ~(op1_neg ^ rem_c) | (op1_neg & ({sum, dvd_lo_next} == '0));
    assign quo     = st_idle ? {{(`IALU_XLEN-1){1'b0}}, quo_bit}
                             : {quo_ff[`IALU_XLEN-2:0], quo_bit};

    always_ff @(posedge clk) begin
        if (dp.upd) begin
            rem_c_ff  <= rem_c;
            rem_ff    <= rem;
            quo_ff    <= quo;
            dvd_lo_ff <= dvd_lo_next;
        end
    end

    // Correction checked on the last iteration only
    assign dp.corr_req = dp.iter_last
                       & ((cmd_sdiv & ops_diff)
                       | (cmd_rem & (|rem) & (op1_neg ^ rem_c)));

    // --------------------------------------------------
    // Result word
    // --------------------------------------------------
    always_comb begin
        case (dp.state)
            ialu_div_pkg::DIV_IDLE : begin
                // Quotient by zero is all ones
                div_res_o = ((|op2_i) | cmd_rem) ? op1_i : '1;
            end
            ialu_div_pkg::DIV_ITER : div_res_o = cmd_rem ? rem : quo;
            ialu_div_pkg::DIV_CORR : div_res_o = cmd_rem ? rem : -quo_ff;
            default                : div_res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/ialu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ialu_macros.svh"

module ialu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_vld_i,  // Level, held until ready
    input  ialu_cmd_pkg::ialu_cmd_e cmd_i,
    input  logic [`IALU_XLEN-1:0]   op1_i,
    input  logic [`IALU_XLEN-1:0]   op2_i,
    output logic [`IALU_XLEN-1:0]   res_o,
    output logic                    res_rdy_o   // Result valid this cycle
);

    logic [`IALU_XLEN-1:0] div_res;     // Divider result to core select

    div_step_if u_step ();

    // Single-cycle ops and final result mux
    alu_core u_core (
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .div_res_i (div_res),
        .res_o     (res_o)
    );

    // Divider FSM and counter
    div_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vld_i (cmd_vld_i),
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .res_rdy_o (res_rdy_o),
        .ctrl      (u_step.ctrl_mp)
    );

    // Divider registers and adder
    div_datapath u_dp (
        .clk       (clk),
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .div_res_o (div_res),
        .dp        (u_step.dp_mp)
    );

endmodule

`default_nettype wire

/* verification/ialu_ref_model.svh */
`ifndef IALU_REF_MODEL_SVH
`define IALU_REF_MODEL_SVH

// Most negative word
localparam logic [`IALU_XLEN-1:0] word_min = {1'b1, {(`IALU_XLEN-1){1'b0}}};

function automatic logic is_div_cmd(input ialu_cmd_pkg::ialu_cmd_e cmd);
    return (cmd == ialu_cmd_pkg::CMD_DIV) || (cmd == ialu_cmd_pkg::CMD_DIVU)
        || (cmd == ialu_cmd_pkg::CMD_REM) || (cmd == ialu_cmd_pkg::CMD_REMU);
endfunction

// Signed divide on magnitudes, truncating toward zero
function automatic logic [`IALU_XLEN-1:0] signed_divide(input logic [`IALU_XLEN-1:0] a,
                                                        input logic [`IALU_XLEN-1:0] b,
                                                        input logic want_rem);
    logic [`IALU_XLEN-1:0] mag_a;
    logic [`IALU_XLEN-1:0] mag_b;
    mag_a = a[`IALU_XLEN-1] ? -a : a;
    mag_b = b[`IALU_XLEN-1] ? -b : b;
    if (want_rem) begin
        return a[`IALU_XLEN-1] ? -(mag_a % mag_b) : (mag_a % mag_b); // Dividend's sign
    end
    return (a[`IALU_XLEN-1] ^ b[`IALU_XLEN-1]) ? -(mag_a / mag_b) : (mag_a / mag_b);
endfunction

function automatic logic [`IALU_XLEN-1:0] expected_result(input ialu_cmd_pkg::ialu_cmd_e cmd,
                                                          input logic [`IALU_XLEN-1:0] a,
                                                          input logic [`IALU_XLEN-1:0] b);
    logic [`IALU_SHAMT_W-1:0] sh;
    logic                     ovf;  // Most negative by -1
    sh  = b[`IALU_SHAMT_W-1:0];
    ovf = (a == word_min) && (b == '1);
    case (cmd)
        ialu_cmd_pkg::CMD_ADD  : return a + b;
        ialu_cmd_pkg::CMD_SUB  : return a - b;
        ialu_cmd_pkg::CMD_SLT  : return {{(`IALU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        ialu_cmd_pkg::CMD_SLTU : return {{(`IALU_XLEN-1){1'b0}}, a < b};
        ialu_cmd_pkg::CMD_AND  : return a & b;
        ialu_cmd_pkg::CMD_OR   : return a | b;
        ialu_cmd_pkg::CMD_XOR  : return a ^ b;
        ialu_cmd_pkg::CMD_SLL  : return a << sh;
        ialu_cmd_pkg::CMD_SRL  : return a >> sh;
        ialu_cmd_pkg::CMD_SRA  : return $signed(a) >>> sh;
        ialu_cmd_pkg::CMD_DIV  : return (b == '0) ? '1 : ovf ? word_min : signed_divide(a, b, 1'b0);
        ialu_cmd_pkg::CMD_DIVU : return (b == '0) ? '1 : (a / b);
        ialu_cmd_pkg::CMD_REM  : return (b == '0) ? a : ovf ? '0 : signed_divide(a, b, 1'b1);
        ialu_cmd_pkg::CMD_REMU : return (b == '0) ? a : (a % b);
        default                : return '0;
    endcase
endfunction

`endif

/* verification/tb_ialu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ialu_macros.svh"

module tb_ialu;

    logic                    clk;
    logic                    rst_n;
    logic                    cmd_vld_i;
    ialu_cmd_pkg::ialu_cmd_e cmd_i;
    logic [`IALU_XLEN-1:0]   op1_i;
    logic [`IALU_XLEN-1:0]   op2_i;
    logic [`IALU_XLEN-1:0]   res_o;
    logic                    res_rdy_o;

    integer                  seed;
    integer                  err_cnt;   // Whole run
    integer                  test_err;  // Current test
    integer                  cmd_cnt;
    integer                  i;
    logic [`IALU_XLEN-1:0]   a;
    logic [`IALU_XLEN-1:0]   b;
    logic [`IALU_XLEN-1:0]   r;

    `include "ialu_ref_model.svh"

    ialu_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vld_i (cmd_vld_i),
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .res_o     (res_o),
        .res_rdy_o (res_rdy_o)
    );

    always #50 clk = ~clk;

    // One in eight is 0, -1 or the most negative value
    task automatic draw_operand(output logic [`IALU_XLEN-1:0] v);
        logic [`IALU_XLEN-1:0] pick;
        pick = $random(seed);
        v    = $random(seed);
        if (pick[2:0] == 3'd0) begin
            v = (pick[4:3] == 2'd0) ? '0 : (pick[4:3] == 2'd1) ? '1 : word_min;
        end
    endtask

    // --------------------------------------------------
    // Command with handshake, value and latency checks
    // --------------------------------------------------
    task automatic run_cmd(input ialu_cmd_pkg::ialu_cmd_e cmd,
                           input logic [`IALU_XLEN-1:0] x,
                           input logic [`IALU_XLEN-1:0] y);
        logic [`IALU_XLEN-1:0] exp_res;
        logic                  imm;     // Ready in the first cycle
        logic                  neg_quo; // Signed quotient of mixed-sign operands
        logic                  lat_ok;
        integer                cycles;
        exp_res = expected_result(cmd, x, y);
        imm     = !is_div_cmd(cmd) || (x == '0) || (y == '0);
        neg_quo = (cmd == ialu_cmd_pkg::CMD_DIV) && (x[`IALU_XLEN-1] != y[`IALU_XLEN-1]);
        cycles  = 0;
        @(posedge clk);
        cmd_vld_i <= 1'b1;
        cmd_i     <= cmd;
        op1_i     <= x;
        op2_i     <= y;
        @(negedge clk);                 // Outputs settled mid-cycle
        while (!res_rdy_o && cycles < 40) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        cmd_cnt = cmd_cnt + 1;
        if (!res_rdy_o) begin
            $display("Timeout: %s op1 %h op2 %h got no result within 40 cycles",
                     cmd.name(), x, y);
            test_err = test_err + 1;
            @(posedge clk);
            cmd_vld_i <= 1'b0;          // FSM falls back to IDLE
        end else begin
            assert (res_o === exp_res) else begin
                $display("** Error at %0t ns: res_o expected %h, actual %h (%s %h %h)",
                         $time, exp_res, res_o, cmd.name(), x, y);
                test_err = test_err + 1;
            end
            // Quotient negation adds the 33rd cycle
            if (imm) begin
                lat_ok = (cycles == 0);
            end else if (cmd == ialu_cmd_pkg::CMD_DIV || cmd == ialu_cmd_pkg::CMD_DIVU) begin
                lat_ok = (cycles == (neg_quo ? 32 : 31));
            end else begin
                lat_ok = (cycles == 31) || (cycles == 32);
            end
            assert (lat_ok) else begin
                $display("Wrong latency: %s op1 %h op2 %h was ready after %0d cycles",
                         cmd.name(), x, y, cycles + 1);
                test_err = test_err + 1;
            end
        end
    endtask

    task automatic drop_valid();
        @(posedge clk);
        cmd_vld_i <= 1'b0;
    endtask

    task automatic close_test(input string name);
        $display("%s: done, %0d errors", name, test_err);
        err_cnt  = err_cnt + test_err;
        test_err = 0;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_vld_i = 1'b0;
        cmd_i     = ialu_cmd_pkg::CMD_ADD;
        op1_i     = '0;
        op2_i     = '0;
        seed      = 32'h18fd;
        err_cnt   = 0;
        test_err  = 0;
        cmd_cnt   = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < 200; i = i + 1) begin
            r = $unsigned($random(seed)) % 10;  // ADD .. SRA
            draw_operand(a);
            draw_operand(b);
            run_cmd(ialu_cmd_pkg::ialu_cmd_e'(r[3:0]), a, b);
        end
        close_test("Test 1 single-cycle commands");

        for (i = 0; i < 60; i = i + 1) begin
            draw_operand(a);
            draw_operand(b);
            run_cmd(i[0] ? ialu_cmd_pkg::CMD_DIVU : ialu_cmd_pkg::CMD_DIV, a, b);
        end
        close_test("Test 2 DIV and DIVU");

        // i[1:0] picks the operand signs
        for (i = 0; i < 64; i = i + 1) begin
            a = $random(seed);
            b = $random(seed);
            a = a >> 1;
            b = b >> (i[3] ? 16 : 1);   // Small divisor now and then
            a = i[0] ? -a : a;
            b = i[1] ? -b : b;
            run_cmd(i[2] ? ialu_cmd_pkg::CMD_REMU : ialu_cmd_pkg::CMD_REM, a, b);
        end
        close_test("Test 3 REM and REMU sign combinations");

        for (i = 0; i < 24; i = i + 1) begin
            r = $random(seed);
            draw_operand(a);
            draw_operand(b);
            if (i[0]) a = '0;
            if (!i[0] || i[1]) b = '0;
            run_cmd(ialu_cmd_pkg::ialu_cmd_e'(4'd10 + {2'b00, r[1:0]}), a, b);
        end
        close_test("Test 4 zero operands");

        run_cmd(ialu_cmd_pkg::CMD_DIV, word_min, '1);
        run_cmd(ialu_cmd_pkg::CMD_REM, word_min, '1);
        run_cmd(ialu_cmd_pkg::CMD_DIVU, word_min, '1);
        run_cmd(ialu_cmd_pkg::CMD_REMU, word_min, '1);
        for (i = 0; i < 40; i = i + 1) begin
            r = $random(seed);
            draw_operand(a);
            draw_operand(b);
            if (r[2]) drop_valid();     // Idle cycle between commands
            run_cmd(ialu_cmd_pkg::ialu_cmd_e'(4'd10 + {2'b00, r[1:0]}), a, b);
        end
        drop_valid();
        close_test("Test 5 overflow and back-to-back divides");

        $display("Summary: 5 tests, %0d commands, %0d errors", cmd_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
+incdir+verification
hw/ialu_cmd_pkg.sv
hw/ialu_div_pkg.sv
hw/div_step_if.sv
hw/alu_core.sv
hw/div_ctrl.sv
hw/div_datapath.sv
hw/ialu_top.sv
verification/tb_ialu.sv

/* Makefile */
SRCS := $(shell grep -v '^+' list.f) hw/ialu_macros.svh verification/ialu_ref_model.svh

.PHONY: run clean

run: obj_dir/Vtb_ialu
	./obj_dir/Vtb_ialu | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

obj_dir/Vtb_ialu: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ialu -f list.f -o Vtb_ialu

clean:
	rm -rf obj_dir sim.log
